/* build.f */
+incdir+rtl
rtl/rom_hash_pkg.sv
rtl/rom_check_pkg.sv
rtl/rom_addr_counter.sv
rtl/rom_hash.sv
rtl/rom_check_fsm.sv
rtl/digest_compare.sv
rtl/rom_check_top.sv
tests/rom_check_assert.sv
tests/rom_check_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the ROM checker testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module rom_check_tb \
  -f build.f -o Vrom_check_tb > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vrom_check_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"

if grep -q "Result: FAILED" "$SIM_LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit 1
fi
exit 0

/* tests/rom_check_tb.sv */
/*
  Directed testbench for the ROM integrity checker.
  The ROM model answers a request one cycle later and inputs change 1 ns after the edge.
  Outputs are sampled on the falling edge where they are stable.
*/
`timescale 1ns/1ps
`include "rom_check_params.svh"

module rom_check_tb;

  import rom_hash_pkg::*;
  import rom_check_pkg::*;

  localparam int Depth    = `ROM_DEPTH;
  localparam int LowWords = `ROM_DEPTH - `ROM_DIGEST_WORDS;
  // Six tests with a generous per-run budget of four cycles per word
  localparam int TimeoutCycles = 6 * (4 * Depth + 20);

  logic                                 clk_i;
  logic                                 rst_ni;
  rom_word_t                            rom_data_i;
  logic                                 rom_req_o;
  logic [`ROM_AW-1:0]                   rom_addr_o;
  logic                                 rom_select_o;
  rom_word_t                            exp_digest_o;
  logic                                 exp_digest_vld_o;
  logic [$clog2(`ROM_DIGEST_WORDS)-1:0] exp_digest_idx_o;
  digest_t                              digest_o;
  logic                                 digest_vld_o;
  pwr_report_t                          pwr_report_o;
  key_report_t                          key_report_o;
  logic                                 alert_o;

  rom_word_t          rom_mem [Depth];
  digest_t            exp_digest;
  logic [31:0]        lfsr_q;
  int                 cycles;
  int                 req_count;
  int                 exp_count;
  logic               digest_seen;
  logic               rd_req;
  logic [`ROM_AW-1:0] rd_addr;

  rom_check_top u_dut (.*);

  always #4 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped after a failed check");
  endtask

  task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
    abort_run($sformatf("Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp));
  endtask

  // Galois LFSR shifting right with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = {value[30:0], lfsr_q[0]};
    end
  endtask

  // Two-lane hash over the low part of the image
  function automatic digest_t ref_hash();
    rom_word_t l0;
    rom_word_t l1;
    l0 = `HASH_SEED0;
    l1 = `HASH_SEED1;
    for (int a = 0; a < LowWords; a++) begin
      l0 = {l0[26:0], l0[31:27]} ^ rom_mem[a];
      l1 = l1 + (rom_mem[a] ^ l0);
    end
    ref_hash = {l1, l0};
  endfunction

  // The expected digest goes into the top words with word 0 at the lowest of them
  task automatic seal_image();
    exp_digest = ref_hash();
    for (int i = 0; i < `ROM_DIGEST_WORDS; i++) begin
      rom_mem[LowWords + i] = exp_digest[i];
    end
  endtask

  task automatic load_random_image();
    logic [31:0] w;
    for (int a = 0; a < LowWords; a++) begin
      draw_bits(32, w);
      rom_mem[a] = w;
    end
    seal_image();
  endtask

  task automatic reset_dut();
    @(posedge clk_i);
    #1;
    rst_ni = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
  endtask

  // ROM model with a one-cycle read that takes the request where it is stable
  always begin
    @(negedge clk_i);
    rd_req  = rom_req_o;
    rd_addr = rom_addr_o;
    @(posedge clk_i);
    #1;
    if (rd_req) begin
      rom_data_i = rom_mem[rd_addr];
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > TimeoutCycles) begin
      abort_run("Timeout: the checker did not finish within the cycle limit");
    end
  end

  // Running checks on every cycle of a run
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      req_count   = 0;
      exp_count   = 0;
      digest_seen = 1'b0;
    end else begin
      assert (!alert_o) else value_error("alert_o", alert_o, 0);
      assert (rom_select_o == !pwr_report_o.done)
        else value_error("rom_select_o", rom_select_o, !pwr_report_o.done);
      // Addresses must come in order and each exactly once
      if (rom_req_o) begin
        assert (req_count < Depth && rom_addr_o == req_count[`ROM_AW-1:0])
          else value_error("rom_addr_o", rom_addr_o, req_count);
        req_count++;
      end
      if (exp_digest_vld_o) begin
        assert (exp_digest_o == rom_mem[LowWords + exp_digest_idx_o])
          else value_error("exp_digest_o", exp_digest_o, rom_mem[LowWords + exp_digest_idx_o]);
        exp_count++;
      end
      if (digest_vld_o) begin
        assert (digest_o == exp_digest) else value_error("digest_o", digest_o, exp_digest);
        digest_seen = 1'b1;
      end
    end
  end

  // Reset, wait for done and check the final reports
  task automatic run_check(input logic expect_good);
    reset_dut();
    do @(negedge clk_i); while (!pwr_report_o.done);
    assert (pwr_report_o.good == expect_good)
      else value_error("pwr_report_o.good", pwr_report_o.good, expect_good);
    assert (digest_seen) else abort_run("digest_vld_o never pulsed before done");
    assert (key_report_o.valid) else value_error("key_report_o.valid", key_report_o.valid, 1);
    assert (key_report_o.digest == exp_digest)
      else value_error("key_report_o.digest", key_report_o.digest, exp_digest);
    assert (req_count == Depth) else value_error("rom_req_o count", req_count, Depth);
    assert (exp_count == `ROM_DIGEST_WORDS)
      else value_error("exp_digest_vld_o count", exp_count, `ROM_DIGEST_WORDS);
  endtask

  task automatic test_good_image();
    load_random_image();
    run_check(1'b1);
  endtask

  // Fixed pattern image whose key report must still hold a few cycles after done
  task automatic test_digest_report();
    for (int a = 0; a < LowWords; a++) begin
      rom_mem[a] = 32'h9e3779b9 * (a + 1);
    end
    seal_image();
    run_check(1'b1);
    repeat (4) @(negedge clk_i);
    assert (key_report_o.valid && key_report_o.digest == exp_digest)
      else value_error("key_report_o.digest", key_report_o.digest, exp_digest);
  endtask

  task automatic test_bad_low_word();
    logic [31:0] addr;
    logic [31:0] bit_pos;
    load_random_image();
    draw_bits(5, addr);
    draw_bits(5, bit_pos);
    rom_mem[addr % LowWords] ^= (32'h1 << bit_pos);
    // The computed digest follows the corrupted data but the stored one does not
    exp_digest = ref_hash();
    run_check(1'b0);
  endtask

  task automatic test_bad_digest_word();
    load_random_image();
    rom_mem[LowWords + 1] ^= 32'h00000100;
    run_check(1'b0);
  endtask

  // Extra cycles after done let the running checks catch a late request
  task automatic test_address_order();
    load_random_image();
    run_check(1'b1);
    repeat (8) @(negedge clk_i);
  endtask

  task automatic test_reset_midrun();
    load_random_image();
    reset_dut();
    while (req_count < Depth / 2) @(negedge clk_i);
    run_check(1'b1);
  endtask

  initial begin
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    rom_data_i = '0;
    lfsr_q     = 32'h8f86861d;
    cycles     = 0;
    test_good_image();
    test_digest_report();
    test_bad_low_word();
    test_bad_digest_word();
    test_address_order();
    test_reset_midrun();
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* tests/rom_check_assert.sv */
/*
  Concurrent checks bound into the ROM checker top level.
  Needs the sequencer state from the FSM instance u_fsm.
  All checks are disabled while reset is low.
*/
`timescale 1ns/1ps
`include "rom_check_params.svh"

module rom_check_assert (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        rom_req_i,
  input logic                        alert_i,
  input rom_check_pkg::pwr_report_t  pwr_report_i,
  input rom_check_pkg::check_state_e state_i
);

  import rom_check_pkg::*;

  // Checking covers the start pulse plus one cycle per digest word
  localparam int CheckCycles = `ROM_DIGEST_WORDS + 1;

  logic in_check;

  assign in_check = (state_i == Checking);

  // A clean image must never trip a consistency check
  no_alert: assert property (@(posedge clk_i) disable iff (!rst_ni) !alert_i)
    else $error("alert_i went high");

  // The ROM is handed back once the check is over
  no_req_after_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pwr_report_i.done |-> !rom_req_i)
    else $error("ROM request seen after done");

  done_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pwr_report_i.done |=> pwr_report_i.done)
    else $error("done fell before reset");

  check_length: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(in_check) |-> ##CheckCycles (state_i == Done))
    else $error("Checking did not reach Done in time");

  // Leaving Checking early or into anything but Done is also a length error
  check_exit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(in_check) |-> (state_i == Done))
    else $error("Checking left into a state other than Done");

endmodule

bind rom_check_top rom_check_assert u_assert (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .rom_req_i    (rom_req_o),
  .alert_i      (alert_o),
  .pwr_report_i (pwr_report_o),
  .state_i      (u_fsm.state_q)
);

/* rtl/rom_check_top.sv */
/*
  Boot-time ROM integrity checker.
  The ROM sits outside and must answer rom_req_o with data one cycle later.
  rom_select_o stays high until the check is done and the ROM is handed back.
  The alert covers both the sequencer and the compare consistency checks.
*/
`timescale 1ns/1ps
`include "rom_check_params.svh"

module rom_check_top (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  rom_hash_pkg::rom_word_t              rom_data_i,
  output logic                                 rom_req_o,
  output logic [`ROM_AW-1:0]                   rom_addr_o,
  output logic                                 rom_select_o,
  output rom_hash_pkg::rom_word_t              exp_digest_o,
  output logic                                 exp_digest_vld_o,
  output logic [$clog2(`ROM_DIGEST_WORDS)-1:0] exp_digest_idx_o,
  output rom_hash_pkg::digest_t                digest_o,
  output logic                                 digest_vld_o,
  output rom_check_pkg::pwr_report_t           pwr_report_o,
  output rom_check_pkg::key_report_t           key_report_o,
  output logic                                 alert_o
);

  import rom_hash_pkg::*;

  logic               data_rdy;
  logic [`ROM_AW-1:0] data_addr;
  logic               data_last_low;
  logic               counter_done;
  hash_beat_t         hash_beat;
  logic               hash_valid;
  logic               hash_ready;
  logic               hash_done;
  digest_t            digest;
  logic               cmp_start;
  logic               cmp_done;
  logic               cmp_good;
  logic               cmp_alert;
  logic               fsm_done;
  logic               fsm_good;
  logic               fsm_alert;

  rom_addr_counter u_counter (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .data_rdy_i      (data_rdy),
    .read_req_o      (rom_req_o),
    .read_addr_o     (rom_addr_o),
    .data_addr_o     (data_addr),
    .data_last_low_o (data_last_low),
    .done_o          (counter_done)
  );

  rom_hash u_hash (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .beat_i       (hash_beat),
    .beat_valid_i (hash_valid),
    .beat_ready_o (hash_ready),
    .done_o       (hash_done),
    .digest_o     (digest)
  );

  rom_check_fsm u_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rom_data_i      (rom_data_i),
    .counter_done_i  (counter_done),
    .data_addr_i     (data_addr),
    .data_last_low_i (data_last_low),
    .hash_ready_i    (hash_ready),
    .hash_done_i     (hash_done),
    .cmp_done_i      (cmp_done),
    .cmp_good_i      (cmp_good),
    .data_rdy_o      (data_rdy),
    .hash_beat_o     (hash_beat),
    .hash_valid_o    (hash_valid),
    .exp_vld_o       (exp_digest_vld_o),
    .exp_idx_o       (exp_digest_idx_o),
    .cmp_start_o     (cmp_start),
    .done_o          (fsm_done),
    .good_o          (fsm_good),
    .alert_o         (fsm_alert)
  );

  digest_compare u_compare (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .exp_vld_i  (exp_digest_vld_o),
    .exp_idx_i  (exp_digest_idx_o),
    .exp_word_i (rom_data_i),
    .digest_i   (digest),
    .start_i    (cmp_start),
    .done_o     (cmp_done),
    .good_o     (cmp_good),
    .alert_o    (cmp_alert)
  );

  // Expected words are the raw ROM data seen while the top part is read
  assign exp_digest_o = rom_data_i;
  assign digest_o     = digest;
  assign digest_vld_o = hash_done;

  assign rom_select_o = ~fsm_done;
  assign pwr_report_o = '{done: fsm_done, good: fsm_good};
  assign key_report_o = '{digest: digest, valid: fsm_done};
  assign alert_o      = fsm_alert | cmp_alert;

endmodule

/* rtl/digest_compare.sv */
/*
  Holds the expected digest words snooped from the ROM top.
  After start it compares one word per cycle against the computed digest.
  done_o comes ROM_DIGEST_WORDS cycles after start and good_o then holds.
  A second start or an index past the last word raises the alert.
*/
`timescale 1ns/1ps
`include "rom_check_params.svh"

module digest_compare (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 exp_vld_i,
  input  logic [$clog2(`ROM_DIGEST_WORDS)-1:0] exp_idx_i,
  input  rom_hash_pkg::rom_word_t              exp_word_i,
  input  rom_hash_pkg::digest_t                digest_i,
  input  logic                                 start_i,
  output logic                                 done_o,
  output logic                                 good_o,
  output logic                                 alert_o
);

  import rom_hash_pkg::*;

  localparam int DIW = $clog2(`ROM_DIGEST_WORDS);
  // One spare index value so that running past the end is visible
  localparam int CW  = $clog2(`ROM_DIGEST_WORDS + 1);
  localparam logic [CW-1:0] LastIdx = CW'(`ROM_DIGEST_WORDS - 1);

  rom_word_t     exp_q [`ROM_DIGEST_WORDS];
  logic [CW-1:0] idx_q;
  logic          active_q;
  logic          started_q;
  logic          good_q;
  logic          match;

  always_ff @(posedge clk_i) begin
    if (exp_vld_i) begin
      exp_q[exp_idx_i] <= exp_word_i;
    end
  end

  assign match = (idx_q <= LastIdx) &&
                 (exp_q[idx_q[DIW-1:0]] == digest_i[idx_q[DIW-1:0]]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q     <= '0;
      active_q  <= 1'b0;
      started_q <= 1'b0;
      good_q    <= 1'b0;
    end else if (start_i) begin
      idx_q     <= '0;
      active_q  <= 1'b1;
      started_q <= 1'b1;
      good_q    <= 1'b1;
    end else if (active_q) begin
      // Any mismatch clears good for the rest of the run
      good_q <= good_q & match;
      idx_q  <= idx_q + 1'b1;
      if (idx_q == LastIdx) begin
        active_q <= 1'b0;
      end
    end
  end

  // Done and good see the last word's result in the same cycle
  assign done_o  = active_q & (idx_q == LastIdx);
  assign good_o  = active_q ? (good_q & match) : good_q;
  assign alert_o = (start_i & started_q) | (active_q & (idx_q > LastIdx));

endmodule

/* rtl/rom_check_fsm.sv */
/*
  Main sequencer of the ROM check.
  Feeds low ROM words to the hash and snoops the top words as expected digest.
  Any out-of-order done, or the counter losing done in Done, locks it in Invalid.
  Invalid raises the alert and is only left by reset.
*/
`timescale 1ns/1ps
`include "rom_check_params.svh"

module rom_check_fsm (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  rom_hash_pkg::rom_word_t               rom_data_i,
  input  logic                                  counter_done_i,
  input  logic [`ROM_AW-1:0]                    data_addr_i,
  input  logic                                  data_last_low_i,
  input  logic                                  hash_ready_i,
  input  logic                                  hash_done_i,
  input  logic                                  cmp_done_i,
  input  logic                                  cmp_good_i,
  output logic                                  data_rdy_o,
  output rom_hash_pkg::hash_beat_t              hash_beat_o,
  output logic                                  hash_valid_o,
  output logic                                  exp_vld_o,
  output logic [$clog2(`ROM_DIGEST_WORDS)-1:0]  exp_idx_o,
  output logic                                  cmp_start_o,
  output logic                                  done_o,
  output logic                                  good_o,
  output logic                                  alert_o
);

  import rom_check_pkg::*;
  import rom_hash_pkg::*;

  localparam int DIW = $clog2(`ROM_DIGEST_WORDS);
  localparam logic [`ROM_AW-1:0] TopStart = `ROM_AW'(`ROM_DEPTH - `ROM_DIGEST_WORDS);

  check_state_e state_q;
  check_state_e state_d;
  logic         fsm_alert;
  logic         counter_alert;
  logic         rd_vld_q;
  logic         data_vld;
  logic         beat_load;
  hash_beat_t   beat_q;
  logic         beat_vld_q;
  logic         start_q;

  // A word is on rom_data_i when a request went out last cycle
  // Counter done masks the cycle after the top word
  assign data_vld  = rd_vld_q & ~counter_done_i;
  assign beat_load = data_vld & (state_q == ReadingLow);

  // In the low part only ask when the hash is ready and nothing is in flight
  // Then the beat register is always free when the word lands
  always_comb begin
    if (state_q == ReadingLow) begin
      data_rdy_o = hash_ready_i & ~rd_vld_q;
    end else begin
      data_rdy_o = state_q inside {ReadingHigh, HashAhead};
    end
  end

  always_comb begin
    state_d   = state_q;
    fsm_alert = 1'b0;
    unique case (state_q)
      ReadingLow: begin
        if (beat_load && data_last_low_i) begin
          state_d = ReadingHigh;
        end
      end
      ReadingHigh: begin
        unique case ({hash_done_i, counter_done_i})
          2'b01:   state_d = RomAhead;
          2'b10:   state_d = HashAhead;
          2'b11:   state_d = Checking;
          default: state_d = ReadingHigh;
        endcase
      end
      RomAhead: begin
        if (hash_done_i) begin
          state_d = Checking;
        end
      end
      HashAhead: begin
        if (counter_done_i) begin
          state_d = Checking;
        end
      end
      Checking: begin
        if (cmp_done_i) begin
          state_d = Done;
        end
      end
      Done: begin
        state_d = Done;
      end
      default: begin
        // Invalid and the unused encoding end up here
        fsm_alert = 1'b1;
        state_d   = Invalid;
      end
    endcase

    // Done signals may only arrive in the states that expect them
    if ((cmp_done_i && !(state_q inside {Checking, Done})) ||
        (counter_done_i && (state_q == ReadingLow)) ||
        (hash_done_i && !(state_q inside {ReadingHigh, RomAhead}))) begin
      state_d = Invalid;
    end
    if (alert_o) begin
      state_d = Invalid;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ReadingLow;
      rd_vld_q   <= 1'b0;
      beat_vld_q <= 1'b0;
      start_q    <= 1'b0;
    end else begin
      state_q  <= state_d;
      rd_vld_q <= data_rdy_o;
      if (beat_load) begin
        beat_vld_q <= 1'b1;
      end else if (hash_ready_i) begin
        beat_vld_q <= 1'b0;
      end
      // One-cycle start pulse in the first Checking cycle
      start_q <= (state_q != Checking) && (state_d == Checking);
    end
  end

  // Beat payload is captured with each returning low word
  always_ff @(posedge clk_i) begin
    if (beat_load) begin
      beat_q <= '{data: rom_data_i, last: data_last_low_i};
    end
  end

  assign hash_beat_o  = beat_q;
  assign hash_valid_o = beat_vld_q;

  // Top words pass by while reading high, indexed from the digest base
  assign exp_vld_o = data_vld & (state_q inside {ReadingHigh, HashAhead});
  assign exp_idx_o = DIW'(data_addr_i - TopStart);

  assign cmp_start_o = start_q;
  assign done_o      = (state_q == Done);
  assign good_o      = done_o & cmp_good_i;

  // Counter done must never drop again after the check has finished
  assign counter_alert = done_o & ~counter_done_i;
  assign alert_o       = fsm_alert | counter_alert;

endmodule

/* rtl/rom_hash.sv */
/*
  Two-lane stand-in for the KMAC engine with a valid/ready word stream.
  Ready drops for one absorb cycle after every accepted beat.
  After the beat flagged last, done_o pulses once and further beats are refused.
  Only reset restarts the hash.
*/
`timescale 1ns/1ps
`include "rom_check_params.svh"

module rom_hash (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  rom_hash_pkg::hash_beat_t beat_i,
  input  logic                     beat_valid_i,
  output logic                     beat_ready_o,
  output logic                     done_o,
  output rom_hash_pkg::digest_t    digest_o
);

  import rom_hash_pkg::*;

  rom_word_t lane0_q;
  rom_word_t lane1_q;
  rom_word_t lane0_d;
  rom_word_t lane1_d;
  logic      busy_q;
  logic      fin_q;
  logic      done_q;
  logic      accept;

  // Busy comes out of reset set, so ready stays low for the first cycle
  assign beat_ready_o = ~busy_q & ~fin_q;
  assign accept       = beat_valid_i & beat_ready_o;

  // Lane 0 rotates left by 5 and folds in the word
  // Lane 1 accumulates the word mixed with the new lane 0
  always_comb begin
    lane0_d = {lane0_q[26:0], lane0_q[31:27]} ^ beat_i.data;
    lane1_d = lane1_q + (beat_i.data ^ lane0_d);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lane0_q <= `HASH_SEED0;
      lane1_q <= `HASH_SEED1;
      busy_q  <= 1'b1;
      fin_q   <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      busy_q <= accept;
      done_q <= accept & beat_i.last;
      if (accept) begin
        lane0_q <= lane0_d;
        lane1_q <= lane1_d;
        if (beat_i.last) begin
          fin_q <= 1'b1;
        end
      end
    end
  end

  assign done_o   = done_q;
  // Lanes stop moving once fin_q is set, so the digest is stable from done on
  assign digest_o = {lane1_q, lane0_q};

endmodule

/* rtl/rom_addr_counter.sv */
/*
  Address generator for the boot-time ROM read.
  Each address from 0 to ROM_DEPTH-1 is requested exactly once.
  The ROM must return data one cycle after the request.
  done_o rises the cycle after the top word was on the data bus and stays set.
*/
`timescale 1ns/1ps
`include "rom_check_params.svh"

module rom_addr_counter (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               data_rdy_i,
  output logic               read_req_o,
  output logic [`ROM_AW-1:0] read_addr_o,
  output logic [`ROM_AW-1:0] data_addr_o,
  output logic               data_last_low_o,
  output logic               done_o
);

  localparam logic [`ROM_AW-1:0] TopAddr     = `ROM_AW'(`ROM_DEPTH - 1);
  localparam logic [`ROM_AW-1:0] LastLowAddr = `ROM_AW'(`ROM_DEPTH - `ROM_DIGEST_WORDS - 1);

  logic [`ROM_AW-1:0] addr_q;
  logic [`ROM_AW-1:0] data_addr_q;
  logic               issued_all_q;
  logic               data_vld_q;
  logic               done_q;

  // A request only goes out when the consumer can take the returning word
  assign read_req_o = data_rdy_i & ~issued_all_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q       <= '0;
      data_addr_q  <= '0;
      issued_all_q <= 1'b0;
      data_vld_q   <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      // Data for this cycle's request shows up on the bus next cycle
      data_vld_q <= read_req_o;
      if (read_req_o) begin
        data_addr_q <= addr_q;
        if (addr_q == TopAddr) begin
          issued_all_q <= 1'b1;
        end else begin
          addr_q <= addr_q + 1'b1;
        end
      end
      // Sticky once the top word has been delivered
      if (data_vld_q && (data_addr_q == TopAddr)) begin
        done_q <= 1'b1;
      end
    end
  end

  assign read_addr_o     = addr_q;
  assign data_addr_o     = data_addr_q;
  assign data_last_low_o = data_vld_q & (data_addr_q == LastLowAddr);
  assign done_o          = done_q;

endmodule

/* rtl/rom_check_pkg.sv */
/*
  Checker sequencing state and the reports sent to the power and key managers.
  Needs rom_hash_pkg compiled first.
  The state encoding is a plain binary enum with no fault hardening.
*/
package rom_check_pkg;

  // Linear sequence of the checker
  // RomAhead and HashAhead are the two sides of the race between ROM and hash
  typedef enum logic [2:0] {
    ReadingLow  = 3'd0,
    ReadingHigh = 3'd1,
    RomAhead    = 3'd2,
    HashAhead   = 3'd3,
    Checking    = 3'd4,
    Done        = 3'd5,
    Invalid     = 3'd6
  } check_state_e;

  // Power manager sees completion and the compare result
  typedef struct packed {
    logic done;
    logic good;
  } pwr_report_t;

  // Key manager gets the computed digest once the check has finished
  typedef struct packed {
    rom_hash_pkg::digest_t digest;
    logic                  valid;
  } key_report_t;

endpackage

/* rtl/rom_hash_pkg.sv */
/*
  Types of the word stream into the hash engine and of its result.
  Compile this package before rom_check_pkg, which builds on its digest type.
  The digest keeps word 0 in the least significant bits.
*/
`include "rom_check_params.svh"

package rom_hash_pkg;

  // One word as read from the ROM
  typedef logic [31:0] rom_word_t;

  // The digest is an array of words with word 0 at the bottom
  typedef rom_word_t [`ROM_DIGEST_WORDS-1:0] digest_t;

  // One beat of the hash stream
  // The last flag marks the final low word of the image
  typedef struct packed {
    rom_word_t data;
    logic      last;
  } hash_beat_t;

endpackage

/* rtl/rom_check_params.svh */
/*
  Build-time configuration of the ROM integrity checker.
  ROM_DEPTH must be a power of two and ROM_AW must equal its log2.
  ROM_DIGEST_WORDS is tied to the two-lane hash engine and must stay 2.
*/
`ifndef ROM_CHECK_PARAMS_SVH
`define ROM_CHECK_PARAMS_SVH

// Number of 32-bit words in the ROM image
`define ROM_DEPTH 32
// Address width of the ROM
`define ROM_AW 5
// Words at the top of the image that hold the expected digest
`define ROM_DIGEST_WORDS 2

// Initial values of the two hash lanes
`define HASH_SEED0 32'h6a09e667
`define HASH_SEED1 32'hbb67ae85

`endif
